// ==== rtl/alu.sv ====
module alu (
    input  rv_pkg::xlen_t   a,
    input  rv_pkg::xlen_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::xlen_t   result
);

    logic [4:0] shamt;

    // shift amount from low bits only
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD: begin
                result = a + b;
            end
            rv_pkg::ALU_SUB: begin
                result = a - b;
            end
            rv_pkg::ALU_AND: begin
                result = a & b;
            end
            rv_pkg::ALU_OR: begin
                result = a | b;
            end
            rv_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            // signed compare
            rv_pkg::ALU_SLT: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            rv_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            // logical right shift
            rv_pkg::ALU_SRL: begin
                result = a >> shamt;
            end
            // lui, immediate straight through
            rv_pkg::ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== rtl/program_memory.sv ====
module program_memory (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               prog,
    input  rv_pkg::byte_t      data,
    input  logic               byte_valid,
    input  rv_pkg::imem_addr_t pc,
    output rv_pkg::instr_t     instr
);

    rv_pkg::instr_t                mem [rv_pkg::IMEM_DEPTH];
    logic [rv_pkg::IMEM_DEPTH-1:0] word_vld;
    logic                          prog_q;
    logic                          prog_rise;
    logic [1:0]                    byte_cnt;
    logic [23:0]                   partial;
    rv_pkg::imem_addr_t            waddr;
    logic                          byte_take;
    logic                          wr_en;

    // new load session on prog rising
    assign prog_rise = prog & ~prog_q;
    assign byte_take = prog && !prog_rise && byte_valid;
    // fourth byte completes a word
    assign wr_en     = byte_take && byte_cnt == 2'd3;

    ////////////////////////////////////////
    // load control
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_q   <= 1'b0;
            byte_cnt <= '0;
            waddr    <= '0;
            word_vld <= '0;
        end else begin
            prog_q <= prog;
            if (prog_rise) begin
                byte_cnt <= '0;
                waddr    <= '0;
                // stale words of the last program read as bubbles
                word_vld <= '0;
            end else if (byte_take) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (wr_en) begin
                    waddr           <= waddr + 1'b1;
                    word_vld[waddr] <= 1'b1;
                end
            end
        end
    end

    // little endian packing
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[waddr] <= {data, partial};
        end else if (byte_take) begin
            case (byte_cnt)
                2'd0:    partial[7:0]   <= data;
                2'd1:    partial[15:8]  <= data;
                default: partial[23:16] <= data;
            endcase
        end
    end

    // async fetch read, unwritten words give 0
    assign instr = word_vld[pc] ? mem[pc] : '0;

endmodule

// ==== rtl/reg_file.sv ====
module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  logic              we,
    input  rv_pkg::xlen_t     wdata,
    output rv_pkg::xlen_t     rdata1,
    output rv_pkg::xlen_t     rdata2,
    input  rv_pkg::reg_addr_t dbg_addr,
    output rv_pkg::xlen_t     dbg_data
);

    // x1..x31, x0 has no storage
    rv_pkg::xlen_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // read ports, old value during a same cycle write
    function automatic rv_pkg::xlen_t read_reg(rv_pkg::reg_addr_t addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    assign rdata1   = read_reg(rs1);
    assign rdata2   = read_reg(rs2);
    // debug port
    assign dbg_data = read_reg(dbg_addr);

endmodule

// ==== rtl/riscv_core_uart.sv ====
module riscv_core_uart (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              prog,
    input  logic              rx,
    input  logic              debug,
    input  rv_pkg::reg_addr_t debug_input,
    output rv_pkg::xlen_t     debug_output
);

    // uart to loader
    rv_pkg::byte_t      rx_data;
    logic               rx_valid;
    // core to instruction memory
    rv_pkg::imem_addr_t pc;
    rv_pkg::instr_t     instr;

    uart_rx u_uart_rx (
        .clk        (clk),
        .arst_n     (arst_n),
        .rx         (rx),
        .data       (rx_data),
        .byte_valid (rx_valid)
    );

    program_memory u_program_memory (
        .clk        (clk),
        .arst_n     (arst_n),
        .prog       (prog),
        .data       (rx_data),
        .byte_valid (rx_valid),
        .pc         (pc),
        .instr      (instr)
    );

    rv_core u_rv_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .prog         (prog),
        .debug        (debug),
        .debug_input  (debug_input),
        .debug_output (debug_output),
        .pc           (pc),
        .instr        (instr)
    );

endmodule

// ==== rtl/rv_core.sv ====
module rv_core (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               prog,
    input  logic               debug,
    input  rv_pkg::reg_addr_t  debug_input,
    output rv_pkg::xlen_t      debug_output,
    output rv_pkg::imem_addr_t pc,
    input  rv_pkg::instr_t     instr
);

    // fetch to execute register
    typedef struct packed {
        logic               valid;
        rv_pkg::imem_addr_t pc;
        rv_pkg::instr_t     instr;
    } fetch_t;

    fetch_t           fetch_q;
    rv_pkg::instr_t   ir;
    logic [2:0]       funct3;
    rv_pkg::decoded_t dec;
    rv_pkg::xlen_t    rdata1;
    rv_pkg::xlen_t    rdata2;
    rv_pkg::xlen_t    dbg_data;
    rv_pkg::xlen_t    alu_b;
    rv_pkg::xlen_t    alu_result;
    rv_pkg::xlen_t    pc_byte;
    rv_pkg::xlen_t    target;
    rv_pkg::xlen_t    link;
    rv_pkg::xlen_t    wdata;
    logic             ex_active;
    logic             reg_we;
    logic             equal;
    logic             taken;

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= '0;
            fetch_q <= '0;
        end else if (prog) begin
            // loading, park at 0 with a bubble
            pc      <= '0;
            fetch_q <= '0;
        end else if (!debug) begin
            if (taken) begin
                // redirect, drop the younger fetch
                pc      <= target[rv_pkg::IMEM_AW+1:2];
                fetch_q <= '0;
            end else begin
                pc      <= pc + 1'b1;
                fetch_q <= '{valid: 1'b1, pc: pc, instr: instr};
            end
        end
        // debug high, everything holds
    end

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    assign ir     = fetch_q.instr;
    assign funct3 = ir[14:12];

    always_comb begin
        dec     = '0;
        dec.rd  = ir[11:7];
        dec.rs1 = ir[19:15];
        dec.rs2 = ir[24:20];
        case (rv_pkg::opcode_e'(ir[6:0]))
            rv_pkg::OP_IMM: begin
                dec.imm       = {{20{ir[31]}}, ir[31:20]};
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = rv_pkg::ALU_ADD;
                    3'b010:  dec.alu_op = rv_pkg::ALU_SLT;
                    3'b100:  dec.alu_op = rv_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = rv_pkg::ALU_OR;
                    3'b111:  dec.alu_op = rv_pkg::ALU_AND;
                    3'b001:  dec.alu_op = rv_pkg::ALU_SLL;
                    3'b101:  dec.alu_op = rv_pkg::ALU_SRL;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            rv_pkg::OP: begin
                dec.reg_write = 1'b1;
                case (funct3)
                    // funct7 bit 5 picks sub
                    3'b000:  dec.alu_op = ir[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b010:  dec.alu_op = rv_pkg::ALU_SLT;
                    3'b100:  dec.alu_op = rv_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = rv_pkg::ALU_OR;
                    3'b111:  dec.alu_op = rv_pkg::ALU_AND;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            rv_pkg::LUI: begin
                dec.imm       = {ir[31:12], 12'b0};
                dec.alu_op    = rv_pkg::ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_pkg::BRANCH: begin
                dec.imm       = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
                // beq and bne only
                dec.is_branch = funct3[2:1] == 2'b00;
                dec.branch_ne = funct3[0];
            end
            rv_pkg::JAL: begin
                dec.imm       = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: begin
                // unknown or zero word, bubble
            end
        endcase
    end

    ////////////////////////////////////////
    // execute and write back
    ////////////////////////////////////////
    // prog has priority over debug
    assign ex_active = fetch_q.valid && !prog && !debug;
    assign alu_b     = dec.use_imm ? dec.imm : rdata2;
    assign equal     = rdata1 == rdata2;
    assign taken     = ex_active && (dec.is_jal || (dec.is_branch && (equal != dec.branch_ne)));

    // byte address of the executing instruction
    assign pc_byte = rv_pkg::xlen_t'({fetch_q.pc, 2'b00});
    assign target  = pc_byte + dec.imm;
    assign link    = pc_byte + 32'd4;

    assign wdata  = dec.is_jal ? link : alu_result;
    assign reg_we = ex_active && dec.reg_write;

    // debug view, 0 when not in debug
    assign debug_output = debug ? dbg_data : '0;

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rd       (dec.rd),
        .we       (reg_we),
        .wdata    (wdata),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .dbg_addr (debug_input),
        .dbg_data (dbg_data)
    );

    alu u_alu (
        .a      (rdata1),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////

    // data path width
    localparam int XLEN = 32;

    // instruction memory, word addressed
    localparam int IMEM_AW    = 6;
    localparam int IMEM_DEPTH = 2 ** IMEM_AW;

    // uart timing, short bit for simulation
    localparam int CLKS_PER_BIT = 16;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [31:0]           instr_t;
    typedef logic [4:0]            reg_addr_t;
    typedef logic [IMEM_AW-1:0]    imem_addr_t;
    typedef logic [7:0]            byte_t;
    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // alu operations, add first so a cleared field means add
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    // decoder output for the execute stage
    typedef struct packed {
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      reg_write;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
    } decoded_t;

endpackage

// ==== rtl/uart_rx.sv ====
module uart_rx (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          rx,
    output rv_pkg::byte_t data,
    output logic          byte_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_e;

    state_e            state;
    logic [1:0]        rx_sync;
    logic              rx_s;
    rv_pkg::baud_cnt_t cnt;
    logic [2:0]        bit_idx;
    rv_pkg::byte_t     shreg;
    logic              bit_end;
    logic              half_end;

    assign rx_s     = rx_sync[1];
    assign bit_end  = cnt == rv_pkg::baud_cnt_t'(rv_pkg::CLKS_PER_BIT - 1);
    assign half_end = cnt == rv_pkg::baud_cnt_t'(rv_pkg::CLKS_PER_BIT / 2 - 1);
    assign data     = shreg;

    // two flop sync, line idles high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    ////////////////////////////////////////
    // receive fsm
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    // falling edge starts a frame
                    if (!rx_s) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (half_end) begin
                        cnt <= '0;
                        // glitch, back to idle
                        state <= rx_s ? S_IDLE : S_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_end) begin
                        // framing error drops the byte
                        byte_valid <= rx_s;
                        state      <= S_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // lsb first, sampled mid bit
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_end) begin
            shreg <= {rx_s, shreg[7:1]};
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# verilator build and run of the core testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 -f tb.f --top-module tb_riscv_core_uart -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// ==== tb.f ====
rtl/rv_pkg.sv
rtl/uart_rx.sv
rtl/program_memory.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/rv_core.sv
rtl/riscv_core_uart.sv
verif/tb_riscv_core_uart.sv

// ==== verif/program_vectors.txt ====
// hex words. record = kind then fields: 1 name_hi name_lo (ascii name)
// 2 count instr... | 3 count (reg value)... | 4 reg (freeze check) | 0 end
// alu ops, lui, signed slt
1 00000061 72697468
2 07 00500093 00c00113 002081b3 40110233 0020f2b3 0020e333 0020c3b3
2 07 0020a433 00409493 00215513 123455b7 fff00613 001626b3 0000006f
3 04 01 00000005 02 0000000c 03 00000011 04 00000007
3 04 05 00000004 06 0000000d 07 00000009 08 00000001
3 05 09 00000050 0a 00000003 0b 12345000 0c ffffffff 0d 00000001
// beq taken skips x3, bne falls through to x4, jal links x5 and skips x6
1 00006272 616e6368
2 05 00300093 00300113 00208463 00100193 00209463
2 04 00200213 008002ef 00700313 0000006f
3 03 01 00000003 03 00000000 04 00000002
3 02 05 0000001c 06 00000000
// writes to x0 dropped, x0 read as zero
1 00000078 7a65726f
2 05 00900013 00400093 00108033 00100133 0000006f
3 03 00 00000000 01 00000004 02 00000004
// x5 counts in a loop, debug freeze
1 00006672 65657a65
2 02 00128293 ffdff06f
4 05
0

// ==== verif/tb_riscv_core_uart.sv ====
module tb_riscv_core_uart;

    // record kinds in the vector file
    typedef enum logic [31:0] {
        K_END    = 32'd0,
        K_NAME   = 32'd1,
        K_PROG   = 32'd2,
        K_EXP    = 32'd3,
        K_FREEZE = 32'd4
    } rec_kind_e;

    logic              clk;
    logic              arst_n;
    logic              prog;
    logic              rx;
    logic              debug;
    rv_pkg::reg_addr_t debug_input;
    rv_pkg::xlen_t     debug_output;

    // raw vector image, 256 words
    logic [31:0]       vec [256];
    // current test, filled by the parser
    rv_pkg::instr_t    prog_words [$];
    rv_pkg::reg_addr_t exp_regs [$];
    rv_pkg::xlen_t     exp_vals [$];
    int                freeze_reg;
    int                test_cnt;
    int                check_cnt;
    int                error_cnt;
    int                cycle_cnt;
    int                cycle_limit;

    riscv_core_uart dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .prog         (prog),
        .rx           (rx),
        .debug        (debug),
        .debug_input  (debug_input),
        .debug_output (debug_output)
    );

    // period 8
    always #4 clk = ~clk;

    // watchdog, limit set once the vectors are scanned
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: simulation did not finish");
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // timing helpers
    ////////////////////////////////////////

    // one cycle, ends just after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            step();
        end
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        prog   = 1'b0;
        debug  = 1'b0;
        rx     = 1'b1;
        wait_cycles(10);
        arst_n = 1'b1;
        step();
    endtask

    // 8N1 frame, lsb first, then a random idle gap
    task automatic send_byte(input rv_pkg::byte_t b);
        int gap;
        rx = 1'b0;
        wait_cycles(rv_pkg::CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            wait_cycles(rv_pkg::CLKS_PER_BIT);
        end
        rx = 1'b1;
        wait_cycles(rv_pkg::CLKS_PER_BIT);
        gap = $urandom % 4;
        wait_cycles(gap);
    endtask

    // low byte goes out first
    task automatic send_word(input rv_pkg::instr_t w);
        for (int k = 0; k < 4; k++) begin
            send_byte(w[8 * k +: 8]);
        end
    endtask

    // select a register, sample mid cycle
    task automatic read_debug(input rv_pkg::reg_addr_t idx, output rv_pkg::xlen_t value);
        debug_input = idx;
        #3;
        value = debug_output;
        step();
    endtask

    task automatic check(
        input string         name,
        input rv_pkg::xlen_t expected,
        input rv_pkg::xlen_t actual
    );
        check_cnt++;
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            error_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // vector file handling
    ////////////////////////////////////////

    // name packed as ascii, leading zero bytes skipped
    function automatic string word_name(input logic [31:0] hi, input logic [31:0] lo);
        logic [63:0] chars;
        string       s;
        chars = {hi, lo};
        s = "";
        for (int i = 7; i >= 0; i--) begin
            if (chars[8 * i +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, chars[8 * i +: 8]);
            end
        end
        return s;
    endfunction

    // uart time of every byte plus a fixed budget per test
    function automatic int scan_limit();
        int p;
        int tests;
        int bytes;
        p     = 0;
        tests = 1;
        bytes = 0;
        while (p < 250 && vec[p] != K_END) begin
            case (vec[p])
                K_NAME: begin
                    tests++;
                    p += 3;
                end
                K_PROG: begin
                    bytes += 4 * int'(vec[p + 1]);
                    p += 2 + int'(vec[p + 1]);
                end
                K_EXP: begin
                    p += 2 + 2 * int'(vec[p + 1]);
                end
                default: begin
                    p += 2;
                end
            endcase
        end
        return bytes * 10 * rv_pkg::CLKS_PER_BIT + 400 * tests + 1000;
    endfunction

    ////////////////////////////////////////
    // test sequences
    ////////////////////////////////////////

    // output masked with debug low, all registers clear
    task automatic reset_test();
        rv_pkg::xlen_t value;
        test_cnt++;
        apply_reset();
        read_debug(5'd1, value);
        check("reset debug low", '0, value);
        debug = 1'b1;
        for (int i = 0; i < 32; i++) begin
            read_debug(rv_pkg::reg_addr_t'(i), value);
            check($sformatf("reset x%0d", i), '0, value);
        end
        debug = 1'b0;
    endtask

    // load, run, then inspect through the debug port
    task automatic run_test(input string name);
        rv_pkg::xlen_t value;
        rv_pkg::xlen_t first_read;
        test_cnt++;
        apply_reset();
        prog = 1'b1;
        step();
        foreach (prog_words[i]) begin
            send_word(prog_words[i]);
        end
        prog = 1'b0;
        // fixed run window, programs end in a self loop
        wait_cycles(200);
        foreach (exp_regs[i]) begin
            read_debug(exp_regs[i], value);
            check($sformatf("%s x%0d debug low", name, exp_regs[i]), '0, value);
        end
        debug = 1'b1;
        foreach (exp_regs[i]) begin
            read_debug(exp_regs[i], value);
            check($sformatf("%s x%0d", name, exp_regs[i]), exp_vals[i], value);
        end
        if (freeze_reg >= 0) begin
            // frozen core, value must hold
            read_debug(rv_pkg::reg_addr_t'(freeze_reg), first_read);
            wait_cycles(20);
            read_debug(rv_pkg::reg_addr_t'(freeze_reg), value);
            check($sformatf("%s x%0d held", name, freeze_reg), first_read, value);
            // released, loop keeps counting
            debug = 1'b0;
            wait_cycles(20);
            debug = 1'b1;
            read_debug(rv_pkg::reg_addr_t'(freeze_reg), value);
            check($sformatf("%s x%0d advances", name, freeze_reg), 32'd1,
                  rv_pkg::xlen_t'(value != first_read));
        end
        debug = 1'b0;
    endtask

    initial begin
        int    p;
        int    n;
        string name;
        clk         = 1'b0;
        arst_n      = 1'b0;
        prog        = 1'b0;
        rx          = 1'b1;
        debug       = 1'b0;
        debug_input = '0;
        test_cnt    = 0;
        check_cnt   = 0;
        error_cnt   = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        void'($urandom(91211));
        foreach (vec[i]) begin
            vec[i] = '0;
        end
        $readmemh("verif/program_vectors.txt", vec);
        cycle_limit = scan_limit();
        reset_test();
        // one pass over the records, one test per name
        p = 0;
        while (p < 253 && vec[p] == K_NAME) begin
            name = word_name(vec[p + 1], vec[p + 2]);
            p += 3;
            prog_words.delete();
            exp_regs.delete();
            exp_vals.delete();
            freeze_reg = -1;
            while (p < 250 && (vec[p] == K_PROG || vec[p] == K_EXP || vec[p] == K_FREEZE)) begin
                n = int'(vec[p + 1]);
                case (vec[p])
                    K_PROG: begin
                        for (int i = 0; i < n; i++) begin
                            prog_words.push_back(vec[p + 2 + i]);
                        end
                        p += 2 + n;
                    end
                    K_EXP: begin
                        for (int i = 0; i < n; i++) begin
                            exp_regs.push_back(rv_pkg::reg_addr_t'(vec[p + 2 + 2 * i]));
                            exp_vals.push_back(vec[p + 3 + 2 * i]);
                        end
                        p += 2 + 2 * n;
                    end
                    default: begin
                        freeze_reg = n;
                        p += 2;
                    end
                endcase
            end
            run_test(name);
        end
        if (test_cnt < 2) begin
            $display("no tests were read from the vector file");
            error_cnt++;
        end
        if (vec[p] != K_END) begin
            $display("the vector file holds a record of unknown kind at word %0d", p);
            error_cnt++;
        end
        $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
